/* src/matrix_pkg.sv */
/*
 * shared definitions for the core/debug bus matrix
 * address constants, widths, transfer codes and the
 * request and address-phase structs
 */

`default_nettype none

package matrix_pkg;

   // ------------------------------------------------------------
   // widths and constants
   // ------------------------------------------------------------

   // address and data width
   localparam int addr_w = 32;
   // transfer size field from the core and the debug port
   localparam int size_w = 2;

   // top address nibble of the private peripheral bus
   localparam logic [3:0] ppb_prefix = 4'hE;

   // only idle and nonseq are ever generated, no bursts
   localparam logic [1:0] htrans_idle   = 2'b00;
   localparam logic [1:0] htrans_nonseq = 2'b10;

   // ------------------------------------------------------------
   // request and phase structs
   // ------------------------------------------------------------

   // core load/store/fetch request
   typedef struct packed {
      logic              spec;      // speculative transfer
      logic              ppb_trans; // access to PPB space
      logic              ext_trans; // access to external AHB
      logic [addr_w-1:0] addr;
      logic [size_w-1:0] size;
      logic              data;      // data not fetch
      logic              write;     // write not read
   } core_req_t;

   // debug slave port request
   typedef struct packed {
      logic              trans;
      logic [addr_w-1:0] addr;
      logic [size_w-1:0] size;
      logic              write;
   } dif_req_t;

   // AHB-Lite master port address phase
   typedef struct packed {
      logic              spec;
      logic [1:0]        htrans;
      logic [addr_w-1:0] haddr;
      logic [2:0]        hsize;
      logic [3:0]        hprot;
      logic              hwrite;
      logic              hmaster;   // 0 core, 1 debug
   } ahb_aphase_t;

   // address phase terms needed in the data phase
   typedef struct packed {
      logic ppb_trans;
      logic dif_aphase;
      logic write;
   } aphase_info_t;

endpackage

`default_nettype wire

/* src/matrix_aphase.sv */
/*
 * address phase of the bus matrix
 * debug slot arbitration, PPB/AHB routing and
 * cacheable/bufferable decode onto the master port
 */

`timescale 1ns/1ps
`default_nettype none

module matrix_aphase #(
   parameter bit dif_en = 1'b1
) (
   input  wire                       hclk,
   input  wire                       reset_i,
   input  matrix_pkg::core_req_t     core_req_i,
   input  matrix_pkg::dif_req_t      dif_req_i,
   output matrix_pkg::ahb_aphase_t   ahb_aphase_o,
   output matrix_pkg::aphase_info_t  info_o,
   output logic                      dif_slot_o
);

   // ------------------------------------------------------------
   // debug port pruning
   // ------------------------------------------------------------

   matrix_pkg::dif_req_t        dif_req;
   logic                        dif_slot;
   logic                        dif_aphase;
   logic                        dif_ppb_sel;
   logic                        ahb_trans;
   logic                        ppb_trans;
   logic                        ahb_prot;
   logic                        ahb_c;
   logic                        ahb_b;
   logic [matrix_pkg::addr_w-1:0] ahb_addr;
   logic [matrix_pkg::size_w-1:0] ahb_size;
   logic                        ahb_write;

   // no debug port means no debug request ever arrives
   assign dif_req = dif_en ? dif_req_i : '0;

   // ------------------------------------------------------------
   // slot and routing
   // ------------------------------------------------------------

   // debug only gets cycles the core may not be using
   assign dif_slot   = ~core_req_i.spec;
   assign dif_aphase = dif_req.trans & dif_slot;

   // PPB occupies the E nibble of the map
   assign dif_ppb_sel = dif_req.addr[31:28] == matrix_pkg::ppb_prefix;

   // core external flag already excludes PPB, just OR in debug
   assign ahb_trans = core_req_i.ext_trans | (dif_aphase & ~dif_ppb_sel);

   // core fetches into PPB are dropped here
   assign ppb_trans = (core_req_i.ppb_trans & core_req_i.data) |
                      (dif_aphase & dif_ppb_sel);

   // debug accesses always count as data
   assign ahb_prot = core_req_i.data | dif_aphase;

   // debug request wins the address phase when it has the slot
   assign ahb_addr  = dif_aphase ? dif_req.addr  : core_req_i.addr;
   assign ahb_size  = dif_aphase ? dif_req.size  : core_req_i.size;
   assign ahb_write = dif_aphase ? dif_req.write : core_req_i.write;

   // ------------------------------------------------------------
   // memory map attributes
   // ------------------------------------------------------------

   // cacheable for the normal memory regions 0-3, 6-9
   assign ahb_c = (~ahb_addr[31] & ahb_addr[29]) |
                  (~ahb_addr[30] & ~ahb_addr[29]);
   // bufferable everywhere except the write-through regions
   assign ahb_b = ahb_addr[30] | ahb_addr[29];

   // ------------------------------------------------------------
   // outputs
   // ------------------------------------------------------------

   // speculative flag may rise without a real transfer
   assign ahb_aphase_o.spec    = core_req_i.spec | dif_req.trans;
   assign ahb_aphase_o.htrans  = ahb_trans ? matrix_pkg::htrans_nonseq
                                           : matrix_pkg::htrans_idle;
   assign ahb_aphase_o.haddr   = ahb_addr;
   assign ahb_aphase_o.hsize   = {1'b0, ahb_size};
   assign ahb_aphase_o.hprot   = {ahb_c, ahb_b, 1'b1, ahb_prot};
   assign ahb_aphase_o.hwrite  = ahb_write;
   assign ahb_aphase_o.hmaster = dif_en ? dif_slot : 1'b0;

   assign dif_slot_o = dif_en ? dif_slot : 1'b0;

   assign info_o.ppb_trans  = ppb_trans;
   assign info_o.dif_aphase = dif_aphase;
   assign info_o.write      = ahb_write;

   // ------------------------------------------------------------
   // checks
   // ------------------------------------------------------------

   // a transfer goes to AHB or to PPB, never both
   a_route_exclusive : assert property (
      @(posedge hclk) disable iff (reset_i)
      !((ahb_aphase_o.htrans == matrix_pkg::htrans_nonseq) && ppb_trans)
   );

endmodule

`default_nettype wire

/* src/matrix_dphase.sv */
/*
 * data phase of the bus matrix
 * PPB and debug data-phase tracking, write data select
 * and PPB masking, debug read merge, response steering
 */

`timescale 1ns/1ps
`default_nettype none

module matrix_dphase #(
   parameter bit dif_en = 1'b1
) (
   input  wire                              hclk,
   input  wire                              reset_i,
   input  matrix_pkg::aphase_info_t         info_i,
   input  wire [matrix_pkg::addr_w-1:0]     core_wdata_i,
   input  wire [matrix_pkg::addr_w-1:0]     dif_wdata_i,
   input  wire [matrix_pkg::addr_w-1:0]     hrdata_i,
   input  wire [matrix_pkg::addr_w-1:0]     ppb_rdata_i,
   input  wire                              hready_i,
   input  wire                              hresp_i,
   output logic [matrix_pkg::addr_w-1:0]    hwdata_o,
   output logic                             ppb_active_o,
   output logic                             ppb_write_o,
   output logic [matrix_pkg::addr_w-1:0]    ppb_wdata_o,
   output logic [matrix_pkg::addr_w-1:0]    dif_rdata_o,
   output logic                             dif_resp_o,
   output logic                             cpu_resp_o
);

   // ------------------------------------------------------------
   // data phase state
   // ------------------------------------------------------------

   logic                          ppb_active_q;
   logic                          ppb_write_q;
   logic                          dif_dphase_q;
   logic [matrix_pkg::addr_w-1:0] dif_wdata;
   logic [matrix_pkg::addr_w-1:0] ahb_wdata;
   logic [matrix_pkg::addr_w-1:0] dif_rdata;

   // address phase moves into data phase on hready only
   always_ff @(posedge hclk) begin
      if (reset_i) begin
         ppb_active_q <= 1'b0;
         ppb_write_q  <= 1'b0;
         dif_dphase_q <= 1'b0;
      end else if (hready_i) begin
         ppb_active_q <= info_i.ppb_trans;
         ppb_write_q  <= info_i.ppb_trans & info_i.write;
         dif_dphase_q <= info_i.dif_aphase;
      end
   end

   // ------------------------------------------------------------
   // write data
   // ------------------------------------------------------------

   assign dif_wdata = dif_en ? dif_wdata_i : '0;

   // data follows whoever owned the previous address phase
   assign ahb_wdata = dif_dphase_q ? dif_wdata : core_wdata_i;

   // PPB write data sits at zero outside a PPB write phase
   // to save toggling on the rarely written PPB
   assign ppb_wdata_o = {matrix_pkg::addr_w{ppb_active_q & ppb_write_q}} & ahb_wdata;

   // ------------------------------------------------------------
   // read data and responses
   // ------------------------------------------------------------

   // PPB read data is zero outside a PPB data phase so a plain OR merges
   assign dif_rdata = ({matrix_pkg::addr_w{~ppb_active_q}} & hrdata_i) | ppb_rdata_i;

   // error for the debug port must not reach the core
   assign cpu_resp_o = hresp_i & ~dif_dphase_q;
   assign dif_resp_o = dif_en ? hresp_i : 1'b0;

   // ------------------------------------------------------------
   // outputs
   // ------------------------------------------------------------

   assign hwdata_o     = ahb_wdata;
   assign ppb_active_o = ppb_active_q;
   assign ppb_write_o  = ppb_write_q;
   assign dif_rdata_o  = dif_en ? dif_rdata : '0;

   // ------------------------------------------------------------
   // checks
   // ------------------------------------------------------------

   // PPB slave keeps its read data quiet outside its phase
   a_ppb_rdata_quiet : assert property (
      @(posedge hclk) disable iff (reset_i)
      !ppb_active_q |-> (ppb_rdata_i == '0)
   );

endmodule

`default_nettype wire

/* src/bus_matrix.sv */
/*
 * bus matrix top level
 * joins the address phase and data phase halves
 */

`timescale 1ns/1ps
`default_nettype none

module bus_matrix #(
   parameter bit dif_en = 1'b1
) (
   input  wire                              hclk,
   input  wire                              reset_i,

   // requesters
   input  matrix_pkg::core_req_t            core_req_i,
   input  matrix_pkg::dif_req_t             dif_req_i,
   input  wire [matrix_pkg::addr_w-1:0]     core_wdata_i,
   input  wire [matrix_pkg::addr_w-1:0]     dif_wdata_i,

   // slave side returns
   input  wire [matrix_pkg::addr_w-1:0]     hrdata_i,
   input  wire [matrix_pkg::addr_w-1:0]     ppb_rdata_i,
   input  wire                              hready_i,
   input  wire                              hresp_i,

   // AHB-Lite master port
   output matrix_pkg::ahb_aphase_t          ahb_aphase_o,
   output logic [matrix_pkg::addr_w-1:0]    hwdata_o,

   // PPB and debug side
   output logic                             dif_slot_o,
   output logic                             ppb_active_o,
   output logic                             ppb_write_o,
   output logic [matrix_pkg::addr_w-1:0]    ppb_wdata_o,
   output logic [matrix_pkg::addr_w-1:0]    dif_rdata_o,
   output logic                             dif_resp_o,
   output logic                             cpu_resp_o
);

   // address phase terms handed over to the data phase
   matrix_pkg::aphase_info_t info;

   // ------------------------------------------------------------
   // address phase
   // ------------------------------------------------------------

   matrix_aphase #(
      .dif_en       (dif_en)
   ) u_aphase (
      .hclk         (hclk),
      .reset_i      (reset_i),
      .core_req_i   (core_req_i),
      .dif_req_i    (dif_req_i),
      .ahb_aphase_o (ahb_aphase_o),
      .info_o       (info),
      .dif_slot_o   (dif_slot_o)
   );

   // ------------------------------------------------------------
   // data phase
   // ------------------------------------------------------------

   matrix_dphase #(
      .dif_en       (dif_en)
   ) u_dphase (
      .hclk         (hclk),
      .reset_i      (reset_i),
      .info_i       (info),
      .core_wdata_i (core_wdata_i),
      .dif_wdata_i  (dif_wdata_i),
      .hrdata_i     (hrdata_i),
      .ppb_rdata_i  (ppb_rdata_i),
      .hready_i     (hready_i),
      .hresp_i      (hresp_i),
      .hwdata_o     (hwdata_o),
      .ppb_active_o (ppb_active_o),
      .ppb_write_o  (ppb_write_o),
      .ppb_wdata_o  (ppb_wdata_o),
      .dif_rdata_o  (dif_rdata_o),
      .dif_resp_o   (dif_resp_o),
      .cpu_resp_o   (cpu_resp_o)
   );

endmodule

`default_nettype wire

/* verif/bus_matrix_tb.sv */
/*
 * trace-driven testbench for the bus matrix
 * clock and reset, trace replay, output checks, watchdog
 */

`timescale 1ns/1ps
`default_nettype none

module bus_matrix_tb;

   // ------------------------------------------------------------
   // trace layout
   // ------------------------------------------------------------

   // 17 stimulus columns then 15 expected output columns
   localparam int cols      = 32;
   localparam int max_lines = 64;
   localparam int depth     = cols * max_lines;

   logic [31:0] trace_mem [0:depth-1];
   int          num_lines;
   bit          loaded;
   int          errors;
   int          checks;
   int          row;

   // DUT side
   logic                            hclk;
   logic                            reset_i;
   matrix_pkg::core_req_t           core_req;
   matrix_pkg::dif_req_t            dif_req;
   logic [matrix_pkg::addr_w-1:0]   core_wdata;
   logic [matrix_pkg::addr_w-1:0]   dif_wdata;
   logic [matrix_pkg::addr_w-1:0]   hrdata;
   logic [matrix_pkg::addr_w-1:0]   ppb_rdata;
   logic                            hready;
   logic                            hresp;
   matrix_pkg::ahb_aphase_t         ahb_aphase;
   logic [matrix_pkg::addr_w-1:0]   hwdata;
   logic                            dif_slot;
   logic                            ppb_active;
   logic                            ppb_write;
   logic [matrix_pkg::addr_w-1:0]   ppb_wdata;
   logic [matrix_pkg::addr_w-1:0]   dif_rdata;
   logic                            dif_resp;
   logic                            cpu_resp;

   bus_matrix #(
      .dif_en       (1'b1)
   ) dut (
      .hclk         (hclk),
      .reset_i      (reset_i),
      .core_req_i   (core_req),
      .dif_req_i    (dif_req),
      .core_wdata_i (core_wdata),
      .dif_wdata_i  (dif_wdata),
      .hrdata_i     (hrdata),
      .ppb_rdata_i  (ppb_rdata),
      .hready_i     (hready),
      .hresp_i      (hresp),
      .ahb_aphase_o (ahb_aphase),
      .hwdata_o     (hwdata),
      .dif_slot_o   (dif_slot),
      .ppb_active_o (ppb_active),
      .ppb_write_o  (ppb_write),
      .ppb_wdata_o  (ppb_wdata),
      .dif_rdata_o  (dif_rdata),
      .dif_resp_o   (dif_resp),
      .cpu_resp_o   (cpu_resp)
   );

   // 10 ns clock
   initial begin
      hclk = 1'b0;
      forever #5 hclk = ~hclk;
   end

   // ------------------------------------------------------------
   // trace handling
   // ------------------------------------------------------------

   // unread words get a tag in the top byte so the line count can be found
   task automatic load_trace();
      for (int i = 0; i < depth; i++) begin
         trace_mem[i] = {8'hee, 24'(i)};
      end
      $readmemh("verif/matrix_trace.txt", trace_mem);
      num_lines = 0;
      while (num_lines < max_lines && trace_mem[num_lines*cols][31:24] != 8'hee) begin
         num_lines++;
      end
   endtask

   task automatic apply_line(input int r);
      int b;
      b = r * cols;
      core_req.spec      <= trace_mem[b][0];
      core_req.ppb_trans <= trace_mem[b+1][0];
      core_req.ext_trans <= trace_mem[b+2][0];
      core_req.data      <= trace_mem[b+3][0];
      core_req.write     <= trace_mem[b+4][0];
      core_req.size      <= trace_mem[b+5][1:0];
      core_req.addr      <= trace_mem[b+6];
      core_wdata         <= trace_mem[b+7];
      dif_req.trans      <= trace_mem[b+8][0];
      dif_req.write      <= trace_mem[b+9][0];
      dif_req.size       <= trace_mem[b+10][1:0];
      dif_req.addr       <= trace_mem[b+11];
      dif_wdata          <= trace_mem[b+12];
      hrdata             <= trace_mem[b+13];
      ppb_rdata          <= trace_mem[b+14];
      hready             <= trace_mem[b+15][0];
      hresp              <= trace_mem[b+16][0];
   endtask

   task automatic compare_field(input int r, input string name,
                                input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("Fail line %0d %s got %h expected %h", r, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_line(input int r);
      int b;
      b = r * cols;
      // address phase, combinational
      compare_field(r, "ahb_aphase_o.spec", 32'(ahb_aphase.spec), trace_mem[b+17]);
      compare_field(r, "ahb_aphase_o.htrans", 32'(ahb_aphase.htrans), trace_mem[b+18]);
      compare_field(r, "ahb_aphase_o.haddr", ahb_aphase.haddr, trace_mem[b+19]);
      compare_field(r, "ahb_aphase_o.hsize", 32'(ahb_aphase.hsize), trace_mem[b+20]);
      compare_field(r, "ahb_aphase_o.hprot", 32'(ahb_aphase.hprot), trace_mem[b+21]);
      compare_field(r, "ahb_aphase_o.hwrite", 32'(ahb_aphase.hwrite), trace_mem[b+22]);
      compare_field(r, "ahb_aphase_o.hmaster", 32'(ahb_aphase.hmaster), trace_mem[b+23]);
      compare_field(r, "dif_slot_o", 32'(dif_slot), trace_mem[b+24]);
      // data phase
      compare_field(r, "hwdata_o", hwdata, trace_mem[b+25]);
      compare_field(r, "ppb_active_o", 32'(ppb_active), trace_mem[b+26]);
      compare_field(r, "ppb_write_o", 32'(ppb_write), trace_mem[b+27]);
      compare_field(r, "ppb_wdata_o", ppb_wdata, trace_mem[b+28]);
      compare_field(r, "dif_rdata_o", dif_rdata, trace_mem[b+29]);
      compare_field(r, "dif_resp_o", 32'(dif_resp), trace_mem[b+30]);
      compare_field(r, "cpu_resp_o", 32'(cpu_resp), trace_mem[b+31]);
   endtask

   // ------------------------------------------------------------
   // watchdog
   // ------------------------------------------------------------

   initial begin
      wait (loaded);
      repeat (num_lines + 20) @(posedge hclk);
      $display("watchdog expired before the trace was replayed");
      $display("TESTS FAILED");
      $finish;
   end

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------

   initial begin
      reset_i    <= 1'b1;
      core_req   <= '0;
      dif_req    <= '0;
      core_wdata <= '0;
      dif_wdata  <= '0;
      hrdata     <= '0;
      ppb_rdata  <= '0;
      hready     <= 1'b1;
      hresp      <= 1'b0;
      errors = 0;
      checks = 0;
      load_trace();
      loaded = 1'b1;
      if (num_lines == 0) begin
         $display("trace file held no stimulus lines");
         errors++;
      end

      repeat (5) @(posedge hclk);
      reset_i <= 1'b0;

      // inputs on the rising edge, outputs sampled mid cycle
      for (row = 0; row < num_lines; row++) begin
         @(posedge hclk);
         apply_line(row);
         @(negedge hclk);
         check_line(row);
      end

      $display("lines: %0d, checks: %0d, errors: %0d", num_lines, checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verif/matrix_trace.txt */
// in:  cs cp ce cd cw csz caddr cwd dt dw dsz daddr dwd hrd prd rdy rsp
// out: spec htr haddr hsz hprot hwr hms slot hwd pa pw pwd drd drs crs
1 0 1 1 0 2 20001000 c0 0 0 0 00000000 d0 50 00 1 0 1 2 20001000 2 f 0 0 0 c0 0 0 00 50 0 0
1 0 1 0 0 1 00000200 c1 0 0 0 00000000 d1 51 00 1 0 1 2 00000200 1 a 0 0 0 c1 0 0 00 51 0 0
1 0 1 1 1 2 60000010 c2 1 1 2 40000020 d2 52 00 1 0 1 2 60000010 2 f 1 0 0 c2 0 0 00 52 0 0
0 0 0 0 0 0 00000000 c3 1 0 2 40000020 d3 53 00 1 0 1 2 40000020 2 7 0 1 1 c3 0 0 00 53 0 0
0 0 0 0 0 0 00000000 c4 1 1 1 80000040 d4 54 00 1 1 1 2 80000040 1 b 1 1 1 d4 0 0 00 54 1 0
0 0 0 0 0 0 10000000 c5 0 0 0 00000000 d5 55 00 1 0 0 0 10000000 0 a 0 1 1 d5 0 0 00 55 0 0
1 1 0 1 1 2 e000e010 c6 0 0 0 00000000 d6 56 00 1 0 1 0 e000e010 2 7 1 0 0 c6 0 0 00 56 0 0
1 1 0 0 0 1 e0001000 c7 0 0 0 00000000 d7 57 00 1 0 1 0 e0001000 1 6 0 0 0 c7 1 1 c7 00 0 0
0 0 0 0 0 0 00000000 c8 1 0 2 e000ed00 d8 58 00 1 0 1 0 e000ed00 2 7 0 1 1 c8 0 0 00 58 0 0
0 0 0 0 0 0 00000000 c9 1 1 2 e000edf0 d9 59 00 0 0 1 0 e000edf0 2 7 1 1 1 d9 1 0 00 00 0 0
0 0 0 0 0 0 00000000 ca 1 1 2 e000edf0 d9 5a 00 0 0 1 0 e000edf0 2 7 1 1 1 d9 1 0 00 00 0 0
0 0 0 0 0 0 00000000 cb 1 1 2 e000edf0 d9 5b 71 1 0 1 0 e000edf0 2 7 1 1 1 d9 1 0 00 71 0 0
1 0 1 1 0 0 30000000 cc 0 0 0 00000000 da 5c 00 1 0 1 2 30000000 0 f 0 0 0 da 1 1 da 00 0 0
1 0 1 1 0 2 50000000 cd 0 0 0 00000000 db 5d 00 1 1 1 2 50000000 2 7 0 0 0 cd 0 0 00 5d 1 1
1 0 1 1 0 2 00000000 e0 0 0 0 00000000 d0 60 00 1 0 1 2 00000000 2 b 0 0 0 e0 0 0 00 60 0 0
1 0 1 0 0 1 10000004 e1 0 0 0 00000000 d0 61 00 1 0 1 2 10000004 1 a 0 0 0 e1 0 0 00 61 0 0
1 0 1 1 0 2 20000008 e2 0 0 0 00000000 d0 62 00 1 0 1 2 20000008 2 f 0 0 0 e2 0 0 00 62 0 0
1 0 1 0 0 1 3000000c e3 0 0 0 00000000 d0 63 00 1 0 1 2 3000000c 1 e 0 0 0 e3 0 0 00 63 0 0
1 0 1 1 0 2 40000010 e4 0 0 0 00000000 d0 64 00 1 0 1 2 40000010 2 7 0 0 0 e4 0 0 00 64 0 0
1 0 1 0 0 1 50000014 e5 0 0 0 00000000 d0 65 00 1 0 1 2 50000014 1 6 0 0 0 e5 0 0 00 65 0 0
1 0 1 1 0 2 60000018 e6 0 0 0 00000000 d0 66 00 1 0 1 2 60000018 2 f 0 0 0 e6 0 0 00 66 0 0
1 0 1 0 0 1 7000001c e7 0 0 0 00000000 d0 67 00 1 0 1 2 7000001c 1 e 0 0 0 e7 0 0 00 67 0 0
1 0 1 1 0 2 80000020 e8 0 0 0 00000000 d0 68 00 1 0 1 2 80000020 2 b 0 0 0 e8 0 0 00 68 0 0
1 0 1 0 0 1 90000024 e9 0 0 0 00000000 d0 69 00 1 0 1 2 90000024 1 a 0 0 0 e9 0 0 00 69 0 0
1 0 1 1 0 2 a0000028 ea 0 0 0 00000000 d0 6a 00 1 0 1 2 a0000028 2 7 0 0 0 ea 0 0 00 6a 0 0
1 0 1 0 0 1 b000002c eb 0 0 0 00000000 d0 6b 00 1 0 1 2 b000002c 1 6 0 0 0 eb 0 0 00 6b 0 0
1 0 1 1 0 2 c0000030 ec 0 0 0 00000000 d0 6c 00 1 0 1 2 c0000030 2 7 0 0 0 ec 0 0 00 6c 0 0
1 0 1 0 0 1 d0000034 ed 0 0 0 00000000 d0 6d 00 1 0 1 2 d0000034 1 6 0 0 0 ed 0 0 00 6d 0 0
1 1 0 0 0 1 e0000038 ee 0 0 0 00000000 d0 6e 00 1 0 1 0 e0000038 1 6 0 0 0 ee 0 0 00 6e 0 0
1 0 1 1 0 2 f000003c ef 0 0 0 00000000 d0 6f 00 1 0 1 2 f000003c 2 7 0 0 0 ef 0 0 00 6f 0 0

/* src.f */
src/matrix_pkg.sv
src/matrix_aphase.sv
src/matrix_dphase.sv
src/bus_matrix.sv
verif/bus_matrix_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the bus matrix testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      -f src.f --top-module bus_matrix_tb -o sim_bus_matrix; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/sim_bus_matrix 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "TESTS PASSED" <<< "$sim_out"; then
   exit 0
fi
exit 1
